// ==== hdl/alu_spec_buffer.sv ====
/*
  Circular FIFO for ALU results with one level of branch speculation
  branch_spec must stay high from its rising edge through the resolve pulse
  A push in the resolve cycle belongs to the branch, kept on correct, lost on mispredict
  Only one unresolved branch at a time; a push while full is lost
*/
`timescale 1ns/1ps
`default_nettype none

module alu_spec_buffer #(
    parameter int DEPTH = 4
) (
    input  logic    CLK,
    input  logic    nRST,
    wb_buf_if.store bus,
    input  logic    branch_spec,
    input  logic    branch_correct,
    input  logic    branch_mispredict
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    wb_pkg::wb_entry_t   mem [DEPTH];
    logic [PTR_W-1:0]    rptr;
    logic [PTR_W-1:0]    wptr;
    logic [PTR_W-1:0]    ckpt_wptr;  // Tail before the first speculative push
    logic [CNT_W-1:0]    count;      // All entries, clean and speculative
    logic [CNT_W-1:0]    spec_cnt;   // Speculative pushes since the checkpoint
    logic [CNT_W-1:0]    clean_cnt;  // Committable entries left while in SPEC
    wb_pkg::spec_state_t state;
    logic                prev_spec;  // branch_spec one cycle back
    logic                do_push;
    logic                do_pop;
    logic                enter_spec;
    logic                resolve;
    logic                rollback;

    assign do_push    = bus.push && !bus.full;
    assign do_pop     = bus.pop && bus.avail;  // Never reaches a speculative entry
    assign enter_spec = (state == wb_pkg::NORMAL) && branch_spec && !prev_spec;
    assign resolve    = (state == wb_pkg::SPEC) && (branch_correct || branch_mispredict);
    assign rollback   = resolve && branch_mispredict;

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wptr] <= bus.push_data;  // Slot past the checkpoint is harmless on rollback
        end
    end

    // Pointers and occupancy
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            if (do_pop) begin
                rptr <= bus.ptr_inc(rptr);
            end
            if (rollback) begin
                wptr  <= ckpt_wptr;  // Same-cycle push discarded as well
                count <= count - CNT_W'(do_pop) - spec_cnt;
            end else begin
                if (do_push) begin
                    wptr <= bus.ptr_inc(wptr);
                end
                count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
            end
        end
    end

    // Speculation bookkeeping
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= wb_pkg::NORMAL;
            prev_spec <= 1'b0;
            ckpt_wptr <= '0;
            spec_cnt  <= '0;
            clean_cnt <= '0;
        end else begin
            prev_spec <= branch_spec;
            if (enter_spec) begin
                state     <= wb_pkg::SPEC;
                ckpt_wptr <= wptr;                        // Tail before this cycle's push
                spec_cnt  <= CNT_W'(do_push);             // Entry cycle push is speculative
                clean_cnt <= count - CNT_W'(do_pop);      // Older entries stay committable
            end else if (resolve) begin
                state    <= wb_pkg::NORMAL;               // Survivors all clean from here
                spec_cnt <= '0;
            end else if (state == wb_pkg::SPEC) begin
                spec_cnt  <= spec_cnt + CNT_W'(do_push);
                clean_cnt <= clean_cnt - CNT_W'(do_pop);
            end
        end
    end

    assign bus.head = mem[rptr];

    // Speculative entries stay hidden from the arbiter
    assign bus.avail = (state == wb_pkg::SPEC) ? (clean_cnt != '0) : (count != '0);
    assign bus.full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== hdl/load_buffer.sv ====
/*
  Circular FIFO for load results, DEPTH of 2 or more
  Status outputs follow the registered count, one edge after a push or pop
  A push while full is lost, producers must stall on the full flag
*/
`timescale 1ns/1ps
`default_nettype none

module load_buffer #(
    parameter int DEPTH = 4
) (
    input  logic     CLK,
    input  logic     nRST,
    wb_buf_if.store  bus
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);  // Count must reach DEPTH

    wb_pkg::wb_entry_t mem [DEPTH];  // Payload storage
    logic [PTR_W-1:0]  rptr;         // Head slot
    logic [PTR_W-1:0]  wptr;         // Next free slot
    logic [CNT_W-1:0]  count;        // Occupancy
    logic              do_push;
    logic              do_pop;

    assign do_push = bus.push && !bus.full;  // Overflowing result is dropped
    assign do_pop  = bus.pop && bus.avail;

    // Payload write, no reset on storage
    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wptr] <= bus.push_data;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rptr  <= '0;
            wptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= bus.ptr_inc(wptr);
            end
            if (do_pop) begin
                rptr <= bus.ptr_inc(rptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);  // Net change per cycle
        end
    end

    assign bus.head  = mem[rptr];
    assign bus.avail = (count != '0);            // Any entry is committable
    assign bus.full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== hdl/wb_arbiter.sv ====
/*
  Picks the single register write of each cycle
  Priority is jump, then bypass, then a buffer pop with round-robin on contention
  Bypass only when neither buffer is avail; ALU bypass also needs branch_spec low
  Results not written this cycle are pushed into their buffer
*/
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                          CLK,
    input  logic                          nRST,
    wb_buf_if.ctrl                        alu_bus,
    wb_buf_if.ctrl                        load_bus,
    input  logic                          alu_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  alu_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     alu_wdat,
    input  logic                          load_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  load_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     load_wdat,
    input  logic                          jump_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  jump_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     jump_wdat,
    input  logic                          branch_spec,
    output logic                          wb_reg_en,
    output logic [wb_pkg::REG_SEL_W-1:0]  wb_reg_sel,
    output logic [wb_pkg::DATA_W-1:0]     wb_wdat,
    output wb_pkg::wb_src_t               wb_src
);

    wb_pkg::wb_entry_t alu_e;
    wb_pkg::wb_entry_t load_e;
    wb_pkg::wb_entry_t jump_e;
    wb_pkg::wb_entry_t out_e;     // Entry on the write port
    logic              any_avail; // Older committable work exists
    logic              contest;   // Both buffers want the port
    logic              rr_alu;    // ALU wins the next contest

    assign alu_e  = '{reg_sel: alu_reg_sel, wdat: alu_wdat};
    assign load_e = '{reg_sel: load_reg_sel, wdat: load_wdat};
    assign jump_e = '{reg_sel: jump_reg_sel, wdat: jump_wdat};

    assign alu_bus.push_data  = alu_e;
    assign load_bus.push_data = load_e;

    assign any_avail = alu_bus.avail || load_bus.avail;
    assign contest   = !jump_done && alu_bus.avail && load_bus.avail;

    always_comb begin
        alu_bus.push  = alu_done;   // Default is to queue every arrival
        load_bus.push = load_done;
        alu_bus.pop   = 1'b0;
        load_bus.pop  = 1'b0;
        out_e         = '0;
        wb_src        = wb_pkg::NONE;
        if (jump_done) begin
            out_e  = jump_e;          // Jump never queues
            wb_src = wb_pkg::JUMP;
        end else if (load_done && !any_avail) begin
            out_e         = load_e;   // Load first when both arrive
            wb_src        = wb_pkg::LOAD;
            load_bus.push = 1'b0;
        end else if (alu_done && !any_avail && !branch_spec) begin
            out_e        = alu_e;
            wb_src       = wb_pkg::ALU;
            alu_bus.push = 1'b0;
        end else if (contest) begin
            if (rr_alu) begin
                out_e       = alu_bus.head;
                wb_src      = wb_pkg::ALU;
                alu_bus.pop = 1'b1;
            end else begin
                out_e        = load_bus.head;
                wb_src       = wb_pkg::LOAD;
                load_bus.pop = 1'b1;
            end
        end else if (alu_bus.avail) begin
            out_e       = alu_bus.head;
            wb_src      = wb_pkg::ALU;
            alu_bus.pop = 1'b1;
        end else if (load_bus.avail) begin
            out_e        = load_bus.head;
            wb_src       = wb_pkg::LOAD;
            load_bus.pop = 1'b1;
        end
    end

    // Flip only after a contested pop, so buffered writes alternate
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_alu <= 1'b0;  // Load buffer served first
        end else if (contest) begin
            rr_alu <= !rr_alu;
        end
    end

    assign wb_reg_en  = (wb_src != wb_pkg::NONE);
    assign wb_reg_sel = out_e.reg_sel;
    assign wb_wdat    = out_e.wdat;

endmodule

`default_nettype wire

// ==== hdl/wb_buf_if.sv ====
/*
  Link between the arbiter and one result buffer
  Pop is only legal while avail is high and takes effect at the next edge
  Push and pop may share a cycle; a push while full is dropped by the buffer
*/
`timescale 1ns/1ps
`default_nettype none

interface wb_buf_if #(
    parameter int DEPTH = 4
);

    localparam int PTR_W = $clog2(DEPTH);  // Slot index width

    logic              push;       // Store push_data at the tail
    wb_pkg::wb_entry_t push_data;
    logic              pop;        // Drop the head entry
    wb_pkg::wb_entry_t head;       // Oldest entry
    logic              avail;      // Head is committable
    logic              full;       // No free slot

    // Circular pointer step, shared by both buffers
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    modport store (
        input  push, push_data, pop,
        output head, avail, full,
        import ptr_inc
    );

    modport ctrl (
        output push, push_data, pop,
        input  head, avail, full
    );

endinterface

`default_nettype wire

// ==== hdl/wb_pkg.sv ====
/*
  Shared types for the writeback stage
  An entry is a register index plus write data, with no valid or source bits
  The source of the current write is reported once, on the wb_src output
*/
`default_nettype none

package wb_pkg;

    // Register file geometry
    parameter int REG_SEL_W = 5;   // 32 architectural registers
    parameter int DATA_W    = 32;  // Write data width

    // One pending register write
    typedef struct packed {
        logic [REG_SEL_W-1:0] reg_sel;  // Destination register
        logic [DATA_W-1:0]    wdat;     // Value to write
    } wb_entry_t;

    // Which producer owns the write port this cycle
    typedef enum logic [1:0] {
        NONE = 2'd0,  // Port idle
        ALU  = 2'd1,
        LOAD = 2'd2,
        JUMP = 2'd3   // Link value from a jump
    } wb_src_t;

    // ALU buffer speculation state
    typedef enum logic {
        NORMAL = 1'b0,  // Every entry committable
        SPEC   = 1'b1   // Branch unresolved, new ALU entries held back
    } spec_state_t;

endpackage

`default_nettype wire

// ==== hdl/writeback.sv ====
/*
  Writeback stage, at most one register write per cycle
  Bypassed results reach the write port in their done cycle, buffered ones later
  Producers must hold done low while their full flag is high
  DEPTH of 2 or more sets both buffers
*/
`timescale 1ns/1ps
`default_nettype none

module writeback #(
    parameter int DEPTH = 4
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          alu_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  alu_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     alu_wdat,
    input  logic                          load_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  load_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     load_wdat,
    input  logic                          jump_done,
    input  logic [wb_pkg::REG_SEL_W-1:0]  jump_reg_sel,
    input  logic [wb_pkg::DATA_W-1:0]     jump_wdat,
    input  logic                          branch_spec,        // Level, high while unresolved
    input  logic                          branch_correct,     // One-cycle pulse
    input  logic                          branch_mispredict,  // One-cycle pulse
    output logic                          wb_reg_en,
    output logic [wb_pkg::REG_SEL_W-1:0]  wb_reg_sel,
    output logic [wb_pkg::DATA_W-1:0]     wb_wdat,
    output wb_pkg::wb_src_t               wb_src,
    output logic                          alu_full,
    output logic                          load_full
);

    wb_buf_if #(.DEPTH(DEPTH)) alu_bus ();
    wb_buf_if #(.DEPTH(DEPTH)) load_bus ();

    alu_spec_buffer #(.DEPTH(DEPTH)) u_alu_buf (
        .CLK               (CLK),
        .nRST              (nRST),
        .bus               (alu_bus.store),
        .branch_spec       (branch_spec),
        .branch_correct    (branch_correct),
        .branch_mispredict (branch_mispredict)
    );

    load_buffer #(.DEPTH(DEPTH)) u_load_buf (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (load_bus.store)
    );

    wb_arbiter u_arb (
        .CLK          (CLK),
        .nRST         (nRST),
        .alu_bus      (alu_bus.ctrl),
        .load_bus     (load_bus.ctrl),
        .alu_done     (alu_done),
        .alu_reg_sel  (alu_reg_sel),
        .alu_wdat     (alu_wdat),
        .load_done    (load_done),
        .load_reg_sel (load_reg_sel),
        .load_wdat    (load_wdat),
        .jump_done    (jump_done),
        .jump_reg_sel (jump_reg_sel),
        .jump_wdat    (jump_wdat),
        .branch_spec  (branch_spec),
        .wb_reg_en    (wb_reg_en),
        .wb_reg_sel   (wb_reg_sel),
        .wb_wdat      (wb_wdat),
        .wb_src       (wb_src)
    );

    // Back-pressure to the producers
    assign alu_full  = alu_bus.full;  // Counts surviving entries after a rollback
    assign load_full = load_bus.full;

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/wb_pkg.sv
hdl/wb_buf_if.sv
hdl/load_buffer.sv
hdl/alu_spec_buffer.sv
hdl/wb_arbiter.sv
hdl/writeback.sv
verif/writeback_properties.sv
verif/tb_writeback.sv

// ==== verif/tb_writeback.sv ====
/*
  Testbench for the writeback stage with DEPTH 4
  Producers stall on the full flags, branch_spec stays high through each resolve pulse
  Expected writes come from per-source queues, open-branch ALU results wait in a side queue
*/
`timescale 1ns/1ps
`default_nettype none

module tb_writeback;

    localparam int DEPTH           = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 40;   // Bound on the directed part
    localparam int RANDOM_CYCLES   = 240;
    localparam int SPEC_LEN        = 12;   // Cycles under one open branch
    localparam int N_WINDOWS       = 4;
    localparam int GAP_CYCLES      = 6;    // Normal traffic after each resolve
    localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + N_WINDOWS * (SPEC_LEN + 1 + GAP_CYCLES);
    localparam int TIMEOUT_CYCLES  = STIM_CYCLES * 4 + 4 * DEPTH + 50;

    logic                         CLK = 1'b0;
    logic                         nRST;
    logic                         alu_done, load_done, jump_done;
    logic [wb_pkg::REG_SEL_W-1:0] alu_reg_sel, load_reg_sel, jump_reg_sel;
    logic [wb_pkg::DATA_W-1:0]    alu_wdat, load_wdat, jump_wdat;
    logic                         branch_spec, branch_correct, branch_mispredict;
    logic                         wb_reg_en;
    logic [wb_pkg::REG_SEL_W-1:0] wb_reg_sel;
    logic [wb_pkg::DATA_W-1:0]    wb_wdat;
    wb_pkg::wb_src_t              wb_src;
    logic                         alu_full, load_full;

    wb_pkg::wb_entry_t alu_q[$];   // Clean ALU results not yet written
    wb_pkg::wb_entry_t spec_q[$];  // ALU results behind the open branch
    wb_pkg::wb_entry_t load_q[$];
    logic [31:0]       lfsr = 32'h6ddb87fd;
    int                checks, value_errs, order_errs, cycle_cnt;
    logic              rr_seen;    // A contested write has happened
    wb_pkg::wb_src_t   last_rr_src;

    writeback #(.DEPTH(DEPTH)) u_writeback (.*);

    always #2 CLK = ~CLK;  // 4 ns period

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};  // One step per bit
        return r;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        value_errs++;
        $display("error: %s got 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        order_errs++;
        $display("%s at %0t", what, $time);
    endtask

    // Compare the current write with the queues, then log this cycle's arrivals
    task automatic check_cycle();
        int                alu_pre;
        int                load_pre;
        logic              have_exp;
        wb_pkg::wb_src_t   exp_src;
        wb_pkg::wb_entry_t exp_e;
        alu_pre  = alu_q.size();   // Held entries stay hidden from the arbiter
        load_pre = load_q.size();
        checks++;
        assert (alu_full == (alu_pre + spec_q.size() == DEPTH))
            else report_mismatch("alu_full", alu_full, !alu_full);
        assert (load_full == (load_pre == DEPTH))
            else report_mismatch("load_full", load_full, !load_full);
        if (alu_done && branch_spec) spec_q.push_back({alu_reg_sel, alu_wdat});
        else if (alu_done) alu_q.push_back({alu_reg_sel, alu_wdat});
        if (load_done) load_q.push_back({load_reg_sel, load_wdat});
        exp_src = wb_pkg::NONE;
        if (jump_done) begin
            exp_src = wb_pkg::JUMP;
        end else if (alu_pre > 0 && load_pre > 0) begin
            // Contests alternate, either side may take the first one
            exp_src = wb_pkg::LOAD;
            if (rr_seen ? (last_rr_src == wb_pkg::LOAD) : (wb_src == wb_pkg::ALU)) begin
                exp_src = wb_pkg::ALU;
            end
            rr_seen     = 1'b1;
            last_rr_src = exp_src;
        end
        else if (alu_pre > 0) exp_src = wb_pkg::ALU;
        else if (load_pre > 0) exp_src = wb_pkg::LOAD;
        else if (load_done) exp_src = wb_pkg::LOAD;  // Load bypasses first
        else if (alu_done && !branch_spec) exp_src = wb_pkg::ALU;
        assert (wb_src == exp_src) else report_mismatch("wb_src", wb_src, exp_src);
        assert (wb_reg_en == (exp_src != wb_pkg::NONE))
            else report_mismatch("wb_reg_en", wb_reg_en, exp_src != wb_pkg::NONE);
        have_exp = 1'b1;
        exp_e    = '0;
        case (wb_src)
            wb_pkg::JUMP: exp_e = {jump_reg_sel, jump_wdat};
            wb_pkg::ALU: begin
                have_exp = (alu_q.size() > 0);
                if (have_exp) exp_e = alu_q.pop_front();
            end
            wb_pkg::LOAD: begin
                have_exp = (load_q.size() > 0);
                if (have_exp) exp_e = load_q.pop_front();
            end
            default:      have_exp = 1'b0;
        endcase
        if (wb_src != wb_pkg::NONE && !have_exp) begin
            report_failure("write appeared with no pending result from its source");
        end else if (have_exp) begin
            assert (wb_reg_sel == exp_e.reg_sel)
                else report_mismatch("wb_reg_sel", wb_reg_sel, exp_e.reg_sel);
            assert (wb_wdat == exp_e.wdat) else report_mismatch("wb_wdat", wb_wdat, exp_e.wdat);
        end
        if (branch_correct) begin
            while (spec_q.size() > 0) alu_q.push_back(spec_q.pop_front());  // Keep order
        end
        if (branch_mispredict) spec_q.delete();
    endtask

    task automatic drive_cycle(input logic want_alu, input logic want_load,
                               input logic want_jump, input logic spec,
                               input logic correct, input logic mispredict);
        @(negedge CLK);
        alu_done          = want_alu && !alu_full;    // Stall while full
        load_done         = want_load && !load_full;
        jump_done         = want_jump;
        alu_reg_sel       = wb_pkg::REG_SEL_W'(rand_bits(wb_pkg::REG_SEL_W));
        alu_wdat          = rand_bits(wb_pkg::DATA_W);
        load_reg_sel      = wb_pkg::REG_SEL_W'(rand_bits(wb_pkg::REG_SEL_W));
        load_wdat         = rand_bits(wb_pkg::DATA_W);
        jump_reg_sel      = wb_pkg::REG_SEL_W'(rand_bits(wb_pkg::REG_SEL_W));
        jump_wdat         = rand_bits(wb_pkg::DATA_W);
        branch_spec       = spec;
        branch_correct    = correct;
        branch_mispredict = mispredict;
        #1;                // Mid low phase, outputs settled
        check_cycle();
    endtask

    task automatic random_traffic(input int n);
        for (int i = 0; i < n; i++) begin
            drive_cycle(rand_bits(2) != 0, rand_bits(2) != 0, rand_bits(3) == 0, 0, 0, 0);
        end
    endtask

    // Open branch for len cycles, then resolve with branch_spec still high
    task automatic spec_window(input int len, input logic bad);
        for (int i = 0; i < len; i++) begin
            drive_cycle(rand_bits(2) != 0, rand_bits(2) != 0, rand_bits(3) == 0, 1, 0, 0);
        end
        drive_cycle(rand_bits(1), rand_bits(1), 1'b0, 1'b1, !bad, bad);
    endtask

    task automatic drain();
        while (alu_q.size() > 0 || load_q.size() > 0) drive_cycle(0, 0, 0, 0, 0, 0);
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        checks     = 0;
        value_errs = 0;
        order_errs = 0;
        rr_seen    = 1'b0;
        {alu_done, load_done, jump_done} = '0;
        {alu_reg_sel, load_reg_sel, jump_reg_sel} = '0;
        {alu_wdat, load_wdat, jump_wdat} = '0;
        {branch_spec, branch_correct, branch_mispredict} = '0;
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        repeat (3) drive_cycle(0, 0, 0, 0, 0, 0);  // Idle port after reset
        drive_cycle(1, 0, 0, 0, 0, 0);             // Lone ALU bypass
        drive_cycle(0, 0, 0, 0, 0, 0);
        drive_cycle(0, 1, 0, 0, 0, 0);             // Lone load bypass
        drive_cycle(0, 0, 1, 0, 0, 0);
        repeat (3) drive_cycle(1, 1, 1, 0, 0, 0);  // Jumps win, others queue
        drain();                                   // Contested drain alternates
        random_traffic(RANDOM_CYCLES);
        for (int w = 0; w < N_WINDOWS; w++) begin
            spec_window(SPEC_LEN, w[0]);           // Correct, then mispredict
            random_traffic(GAP_CYCLES);
        end
        drain();
        repeat (2) drive_cycle(0, 0, 0, 0, 0, 0);
        $display("checks %0d, value errors %0d, order errors %0d, property failures %0d",
                 checks, value_errs, order_errs, u_writeback.u_props.fail_cnt);
        if (value_errs + order_errs + u_writeback.u_props.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/writeback_properties.sv ====
/*
  Concurrent checks on the writeback stage, bound into every writeback instance
  Assumes branch_spec stays high from its rising edge through the resolve pulse
*/
`timescale 1ns/1ps
`default_nettype none

module writeback_properties (
    input logic                CLK,
    input logic                nRST,
    input logic                alu_push,
    input logic                alu_full,
    input logic                load_push,
    input logic                load_full,
    input logic                jump_done,
    input logic                branch_spec,
    input logic                wb_reg_en,
    input wb_pkg::wb_src_t     wb_src,
    input wb_pkg::spec_state_t alu_state
);

    int fail_cnt = 0;  // Failed assertions so far

    // Producers must stall on the full flags
    no_alu_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(alu_push && alu_full))
        else begin
            fail_cnt++;
            $error("ALU result pushed into a full buffer");
        end

    no_load_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        !(load_push && load_full))
        else begin
            fail_cnt++;
            $error("load result pushed into a full buffer");
        end

    en_matches_src: assert property (@(posedge CLK) disable iff (!nRST)
        wb_reg_en == (wb_src != wb_pkg::NONE))
        else begin
            fail_cnt++;
            $error("wb_reg_en disagrees with wb_src");
        end

    jump_wins: assert property (@(posedge CLK) disable iff (!nRST)
        jump_done |-> wb_src == wb_pkg::JUMP)
        else begin
            fail_cnt++;
            $error("jump result did not take the write port");
        end

    // Speculation never outlives its branch
    spec_needs_branch: assert property (@(posedge CLK) disable iff (!nRST)
        alu_state == wb_pkg::SPEC |-> branch_spec)
        else begin
            fail_cnt++;
            $error("ALU buffer speculative with no open branch");
        end

endmodule

bind writeback writeback_properties u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .alu_push    (alu_bus.push),
    .alu_full    (alu_full),
    .load_push   (load_bus.push),
    .load_full   (load_full),
    .jump_done   (jump_done),
    .branch_spec (branch_spec),
    .wb_reg_en   (wb_reg_en),
    .wb_src      (wb_src),
    .alu_state   (u_alu_buf.state)
);

`default_nettype wire
